//--- rtl/core_ctrl.sv
// --------------------------------------
// Core control FSM
// Owns the pc, takes interrupts and debug at boundaries
// Issues fetch commands and writes the trace record
// --------------------------------------

`timescale 1ns/1ps

module core_ctrl #(
  parameter logic [31:0] BootAddr   = 32'h0000_0080,
  parameter logic [31:0] MtvecBase  = 32'h0000_1000,
  parameter logic [31:0] DmHaltAddr = 32'h1A11_0800
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       fetch_enable_i,
  input  logic                       debug_req_i,
  input  logic                       debug_resume_i,
  input  core_shell_pkg::irq_sel_t   sel_i,
  output core_shell_pkg::fetch_cmd_t cmd_o,
  input  core_shell_pkg::fetch_rsp_t rsp_i,
  output logic                       irq_ack_o,
  output logic [4:0]                 irq_id_o,
  output logic                       debug_mode_o,
  output core_shell_pkg::trace_t     trace_o
);

  // Boot loads the pc, issue sends start, wait expects done
  typedef enum logic [1:0] {
    ST_BOOT,
    ST_ISSUE,
    ST_WAIT
  } state_e;

  state_e      state_q;
  logic [31:0] pc_q;
  logic [31:0] dpc_q;
  logic        debug_mode_q;
  logic        resume_q;
  logic        irq_ack_q;
  logic [4:0]  irq_id_q;

  // Trace record, valid kept apart from payload
  logic        trace_valid_q;
  logic [31:0] trace_pc_q;
  logic [31:0] trace_instr_q;
  logic        trace_dbg_q;

  // Boundary decode
  logic        boundary;
  logic        take_debug;
  logic        take_resume;
  logic        take_irq;
  logic [31:0] pc_seq;
  logic [31:0] pc_next;

  // --------------------------------------
  // Boundary decision
  assign boundary = (state_q == ST_WAIT) && rsp_i.done;
  assign pc_seq   = pc_q + 32'd4;

  // Fixed priority, debug entry first
  assign take_debug  = debug_req_i && !debug_mode_q;
  assign take_resume = !take_debug && debug_mode_q && resume_q;
  assign take_irq    = !take_debug && !debug_mode_q && sel_i.pending;

  always_comb begin
    if (take_debug) begin
      pc_next = DmHaltAddr;
    end else if (take_resume) begin
      pc_next = dpc_q;
    end else if (take_irq) begin
      // Vectored, four bytes per cause
      pc_next = MtvecBase + 32'({sel_i.id, 2'b00});
    end else begin
      pc_next = pc_seq;
    end
  end

  // --------------------------------------
  // Control state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q       <= ST_BOOT;
      debug_mode_q  <= 1'b0;
      resume_q      <= 1'b0;
      irq_ack_q     <= 1'b0;
      irq_id_q      <= 5'd0;
      trace_valid_q <= 1'b0;
    end else begin
      // Trace valid and ack line up one cycle after done
      trace_valid_q <= boundary;
      irq_ack_q     <= boundary && take_irq;

      // Resume only means something in debug mode
      if (debug_resume_i && debug_mode_q) begin
        resume_q <= 1'b1;
      end

      case (state_q)
        ST_BOOT: begin
          state_q <= ST_ISSUE;
        end

        ST_ISSUE: begin
          // Stall here while fetch is disabled
          if (fetch_enable_i) begin
            state_q <= ST_WAIT;
          end
        end

        ST_WAIT: begin
          if (rsp_i.done) begin
            state_q <= ST_ISSUE;
            if (take_debug) begin
              debug_mode_q <= 1'b1;
            end
            if (take_resume) begin
              debug_mode_q <= 1'b0;
              resume_q     <= 1'b0;
            end
            // Id stays until the next taken interrupt
            if (take_irq) begin
              irq_id_q <= sel_i.id;
            end
          end
        end

        default: begin
          state_q <= ST_BOOT;
        end
      endcase
    end
  end

  // --------------------------------------
  // Pc, saved pc and trace payload
  always_ff @(posedge clk_i) begin
    if (state_q == ST_BOOT) begin
      pc_q <= BootAddr;
    end else if (boundary) begin
      pc_q <= pc_next;
    end

    // Return point is the word that would have come next
    if (boundary && take_debug) begin
      dpc_q <= pc_seq;
    end

    if (boundary) begin
      trace_pc_q    <= pc_q;
      trace_instr_q <= rsp_i.instr;
      trace_dbg_q   <= debug_mode_q;
    end
  end

  // Start pulses in the cycle after done
  assign cmd_o = '{start: (state_q == ST_ISSUE) && fetch_enable_i, addr: pc_q};

  assign irq_ack_o    = irq_ack_q;
  assign irq_id_o     = irq_id_q;
  assign debug_mode_o = debug_mode_q;

  assign trace_o = '{valid: trace_valid_q,
                     pc:    trace_pc_q,
                     instr: trace_instr_q,
                     dbg:   trace_dbg_q};

endmodule

//--- rtl/core_shell_pkg.sv
// --------------------------------------
// Shared types for the fetch-side core shell
// Bus, fetch, interrupt and trace bundles
// Referenced by scoped name from each RTL file
// --------------------------------------

package core_shell_pkg;

  // Interrupt word, CV32E20 bit layout
  typedef struct packed {
    logic [15:0] fast;
    logic [3:0]  rsvd_15_12;
    logic        external;
    logic [2:0]  rsvd_10_8;
    logic        timer;
    logic [2:0]  rsvd_6_4;
    logic        software;
    logic [1:0]  rsvd_2_1;
    logic        nmi;
  } irq_fields_t;

  // Flat view for merging, field view for priority
  typedef union packed {
    logic [31:0] raw;
    irq_fields_t fields;
  } irq_word_u;

  // Cause ids reported on irq_id
  localparam logic [4:0] CAUSE_NMI       = 5'd31;
  localparam logic [4:0] CAUSE_FAST_BASE = 5'd16;
  localparam logic [4:0] CAUSE_EXT       = 5'd11;
  localparam logic [4:0] CAUSE_SW        = 5'd3;
  localparam logic [4:0] CAUSE_TIMER     = 5'd7;

  // --------------------------------------
  // OBI instruction bus, read only
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_rsp_t;

  // --------------------------------------
  // Ctrl to fetch unit and back
  typedef struct packed {
    logic        start;
    logic [31:0] addr;
  } fetch_cmd_t;

  typedef struct packed {
    logic        done;
    logic [31:0] instr;
  } fetch_rsp_t;

  // Selected interrupt
  typedef struct packed {
    logic       pending;
    logic [4:0] id;
  } irq_sel_t;

  // One record per fetched word
  typedef struct packed {
    logic        valid;
    logic [31:0] pc;
    logic [31:0] instr;
    logic        dbg;
  } trace_t;

endpackage

//--- rtl/core_shell_top.sv
// --------------------------------------
// Core shell top level
// Read-only OBI fetch, interrupts, debug and trace
// Address parameters are set here and passed to ctrl
// --------------------------------------

`timescale 1ns/1ps

module core_shell_top #(
  parameter logic [31:0] BootAddr   = 32'h0000_0080,
  parameter logic [31:0] MtvecBase  = 32'h0000_1000,
  parameter logic [31:0] DmHaltAddr = 32'h1A11_0800
) (
  input  logic                      clk_i,
  input  logic                      rst_i,

  // Instruction bus, no we or be
  output core_shell_pkg::obi_req_t  instr_bus_o,
  input  core_shell_pkg::obi_rsp_t  instr_bus_i,

  // Interrupt sources and acknowledge
  input  core_shell_pkg::irq_word_u irq_i,
  input  core_shell_pkg::irq_word_u irq_vp_i,
  output logic                      irq_ack_o,
  output logic [4:0]                irq_id_o,

  // Debug and run control
  input  logic                      debug_req_i,
  input  logic                      debug_resume_i,
  input  logic                      fetch_enable_i,
  output logic                      debug_mode_o,

  // One record per fetched word
  output core_shell_pkg::trace_t    trace_o
);

  // --------------------------------------
  // Internal links
  core_shell_pkg::fetch_cmd_t fetch_cmd;
  core_shell_pkg::fetch_rsp_t fetch_rsp;
  core_shell_pkg::irq_sel_t   irq_sel;

  // Pc, boundary decisions and trace
  core_ctrl #(
    .BootAddr   (BootAddr),
    .MtvecBase  (MtvecBase),
    .DmHaltAddr (DmHaltAddr)
  ) u_core_ctrl (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .fetch_enable_i (fetch_enable_i),
    .debug_req_i    (debug_req_i),
    .debug_resume_i (debug_resume_i),
    .sel_i          (irq_sel),
    .cmd_o          (fetch_cmd),
    .rsp_i          (fetch_rsp),
    .irq_ack_o      (irq_ack_o),
    .irq_id_o       (irq_id_o),
    .debug_mode_o   (debug_mode_o),
    .trace_o        (trace_o)
  );

  // Bus master
  fetch_unit u_fetch_unit (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .cmd_i (fetch_cmd),
    .rsp_o (fetch_rsp),
    .bus_o (instr_bus_o),
    .bus_i (instr_bus_i)
  );

  // Cause select, combinational
  irq_prio u_irq_prio (
    .irq_i    (irq_i),
    .irq_vp_i (irq_vp_i),
    .sel_o    (irq_sel)
  );

endmodule

//--- rtl/fetch_unit.sv
// --------------------------------------
// OBI instruction fetch master
// One word per start pulse, one transaction in flight
// Done pulses one cycle after rvalid with the word
// --------------------------------------

`timescale 1ns/1ps

module fetch_unit (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  core_shell_pkg::fetch_cmd_t cmd_i,
  output core_shell_pkg::fetch_rsp_t rsp_o,
  output core_shell_pkg::obi_req_t   bus_o,
  input  core_shell_pkg::obi_rsp_t   bus_i
);

  // Idle, address phase, response phase
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_DATA
  } state_e;

  state_e      state_q;
  logic        done_q;
  logic [31:0] addr_q;
  logic [31:0] instr_q;

  // --------------------------------------
  // Control state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      // Done is a single-cycle pulse
      done_q <= 1'b0;

      case (state_q)
        ST_IDLE: begin
          // Req goes out the cycle after start
          if (cmd_i.start) begin
            state_q <= ST_REQ;
          end
        end

        ST_REQ: begin
          // Hold req and addr until accepted
          if (bus_i.gnt) begin
            state_q <= ST_DATA;
          end
        end

        ST_DATA: begin
          // Response never shares the grant cycle
          if (bus_i.rvalid) begin
            done_q  <= 1'b1;
            state_q <= ST_IDLE;
          end
        end

        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // --------------------------------------
  // Address and read data
  always_ff @(posedge clk_i) begin
    // Address captured with the command
    if (state_q == ST_IDLE && cmd_i.start) begin
      addr_q <= cmd_i.addr;
    end
    // Word captured on rvalid
    if (state_q == ST_DATA && bus_i.rvalid) begin
      instr_q <= bus_i.rdata;
    end
  end

  // Address phase driven straight from state
  assign bus_o = '{req: (state_q == ST_REQ), addr: addr_q};

  assign rsp_o = '{done: done_q, instr: instr_q};

endmodule

//--- rtl/irq_prio.sv
// --------------------------------------
// Interrupt merge and priority select
// ORs the two vectors, then picks one cause id
// Purely combinational, feeds the boundary logic in ctrl
// --------------------------------------

`timescale 1ns/1ps

module irq_prio (
  input  core_shell_pkg::irq_word_u irq_i,
  input  core_shell_pkg::irq_word_u irq_vp_i,
  output core_shell_pkg::irq_sel_t  sel_o
);

  // Merged word, both views used
  core_shell_pkg::irq_word_u merged;

  logic       any_mapped;
  logic [4:0] id_sel;

  // Merge on the flat view
  assign merged.raw = irq_i.raw | irq_vp_i.raw;

  // Only mapped lines count, reserved bits dropped
  assign any_mapped = merged.fields.nmi
                    | (|merged.fields.fast)
                    | merged.fields.external
                    | merged.fields.software
                    | merged.fields.timer;

  // --------------------------------------
  // Priority chain
  // Lowest priority written first, later checks override
  always_comb begin
    id_sel = 5'd0;

    // Timer below software below external
    if (merged.fields.timer) begin
      id_sel = core_shell_pkg::CAUSE_TIMER;
    end
    if (merged.fields.software) begin
      id_sel = core_shell_pkg::CAUSE_SW;
    end
    if (merged.fields.external) begin
      id_sel = core_shell_pkg::CAUSE_EXT;
    end

    // Fast lines, higher index wins
    for (int i = 0; i < 16; i++) begin
      if (merged.fields.fast[i]) begin
        id_sel = 5'(core_shell_pkg::CAUSE_FAST_BASE + i);
      end
    end

    // NMI beats everything
    if (merged.fields.nmi) begin
      id_sel = core_shell_pkg::CAUSE_NMI;
    end
  end

  // Id is don't-care while nothing is pending
  assign sel_o = '{pending: any_mapped, id: id_sel};

endmodule

//--- run.sh
#!/bin/sh
# Build the core shell testbench with Verilator and run it
# Exit status is zero only when the run prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_core_shell -f sim.f -o tb_core_shell \
  && ./obj_dir/tb_core_shell | tee /dev/stderr | grep -q "TEST PASS" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sim.f
rtl/core_shell_pkg.sv
rtl/irq_prio.sv
rtl/fetch_unit.sv
rtl/core_ctrl.sv
rtl/core_shell_top.sv
verif/tb_obi_mem.sv
verif/tb_core_shell.sv

//--- verif/tb_core_shell.sv
// --------------------------------------
// Testbench for the core shell
// Runs fetch, interrupt and debug phases against a pc model
// OBI, reset and fetch enable rules checked by assertions
// --------------------------------------

`timescale 1ns/1ps

module tb_core_shell;

  localparam logic [31:0] BOOT_ADDR = 32'h0000_0080;
  localparam logic [31:0] MTVEC     = 32'h0000_1000;
  localparam logic [31:0] DM_HALT   = 32'h1A11_0800;
  localparam logic [31:0] FILL_KEY  = 32'ha5a5_5a5a;
  // Nmi, software, timer, external and fast lines
  localparam logic [31:0] MAPPED    = 32'hFFFF_0889;

  // Expected trace items per phase
  // Watchdog limit is derived from these
  localparam int SEQ_ITEMS   = 12;
  localparam int IRQ_ITEMS   = 32;
  localparam int DBG_ITEMS   = 14;
  localparam int TOTAL_ITEMS = SEQ_ITEMS + 2 + IRQ_ITEMS + DBG_ITEMS;
  localparam int WATCHDOG    = 40 * TOTAL_ITEMS + 16 + 8 + 20;

  // Single and combined lines over both vectors
  // Last case drives reserved bits only
  localparam logic [31:0] IRQ_CASES [0:7] = '{
    32'h0000_0080, 32'h0000_0000, 32'h0000_0008, 32'h0000_0800,
    32'h0000_0001, 32'h8001_0000, 32'h0000_F776, 32'h0000_F776};
  localparam logic [31:0] VP_CASES [0:7] = '{
    32'h0000_0000, 32'h0000_0008, 32'h0000_0080, 32'h0008_0000,
    32'h0080_0000, 32'h0000_0000, 32'h0000_0800, 32'h0000_0000};

  logic clk           = 1'b0;
  logic rst           = 1'b1;
  logic fetch_enable  = 1'b0;
  logic debug_req     = 1'b0;
  logic debug_resume  = 1'b0;
  logic req_forbidden = 1'b0;
  logic irq_load      = 1'b0;
  logic [31:0] irq_new    = 32'd0;
  logic [31:0] irq_vp_new = 32'd0;
  core_shell_pkg::irq_word_u irq    = '0;
  core_shell_pkg::irq_word_u irq_vp = '0;

  core_shell_pkg::obi_req_t bus_req;
  core_shell_pkg::obi_rsp_t bus_rsp;
  core_shell_pkg::trace_t   trace;
  logic       irq_ack;
  logic [4:0] irq_id;
  logic       debug_mode;

  // Reference model state
  logic [31:0] exp_pc      = BOOT_ADDR;
  logic [31:0] exp_dpc     = 32'd0;
  logic        exp_dbg     = 1'b0;
  logic        resume_seen = 1'b0;
  logic        dreq_d      = 1'b0;
  logic [31:0] irq_d       = 32'd0;
  logic        take_irq    = 1'b0;
  logic [4:0]  cause       = 5'd0;
  logic        outstanding = 1'b0;

  core_shell_top #(
    .BootAddr   (BOOT_ADDR),
    .MtvecBase  (MTVEC),
    .DmHaltAddr (DM_HALT)
  ) u_core_shell_top (
    .clk_i          (clk),
    .rst_i          (rst),
    .instr_bus_o    (bus_req),
    .instr_bus_i    (bus_rsp),
    .irq_i          (irq),
    .irq_vp_i       (irq_vp),
    .irq_ack_o      (irq_ack),
    .irq_id_o       (irq_id),
    .debug_req_i    (debug_req),
    .debug_resume_i (debug_resume),
    .fetch_enable_i (fetch_enable),
    .debug_mode_o   (debug_mode),
    .trace_o        (trace)
  );

  tb_obi_mem #(
    .Seed    (32'h1e54_c0c2),
    .FillKey (FILL_KEY)
  ) u_obi_mem (
    .clk_i (clk),
    .rst_i (rst),
    .bus_i (bus_req),
    .bus_o (bus_rsp)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] got);
    stop_on_failure($sformatf("ERR time=%0t %s expected=0x%08h actual=0x%08h",
                              $time, sig, exp, got));
  endtask

  // Nmi first, fast 15 down to 0, then external, software, timer
  function automatic logic [4:0] expected_cause(input logic [31:0] raw);
    if (raw[0]) begin
      return 5'd31;
    end
    for (int n = 15; n >= 0; n--) begin
      if (raw[16 + n]) begin
        return 5'(16 + n);
      end
    end
    if (raw[11]) begin
      return 5'd11;
    end
    if (raw[3]) begin
      return 5'd3;
    end
    return 5'd7;
  endfunction

  // Nmi and fast line 15 share id 31
  function automatic logic [31:0] lines_for_id(input logic [4:0] id);
    if (id == 5'd31) begin
      return 32'h8000_0001;
    end
    return 32'h1 << id;
  endfunction

  task automatic wait_traces(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      while (!trace.valid) begin
        @(posedge clk);
      end
    end
  endtask

  // --------------------------------------
  // Each interrupt source drops its line after its ack
  always @(posedge clk) begin
    if (irq_load) begin
      irq.raw    <= irq_new;
      irq_vp.raw <= irq_vp_new;
    end else if (irq_ack) begin
      irq.raw    <= irq.raw & ~lines_for_id(irq_id);
      irq_vp.raw <= irq_vp.raw & ~lines_for_id(irq_id);
    end
  end

  // --------------------------------------
  // Reference pc model
  // Delayed inputs line up with the done cycle of each trace item
  always @(posedge clk) begin
    dreq_d <= debug_req;
    irq_d  <= irq.raw | irq_vp.raw;
    if (debug_resume && exp_dbg) begin
      resume_seen = 1'b1;
    end
    if (!rst && trace.valid) begin
      assert (trace.pc == exp_pc)
        else report_mismatch("trace_o.pc", exp_pc, trace.pc);
      assert (trace.instr == (exp_pc ^ FILL_KEY))
        else report_mismatch("trace_o.instr", exp_pc ^ FILL_KEY, trace.instr);
      assert (trace.dbg == exp_dbg)
        else report_mismatch("trace_o.dbg", 32'(exp_dbg), 32'(trace.dbg));
      take_irq = 1'b0;
      if (dreq_d && !exp_dbg) begin
        exp_dpc = exp_pc + 32'd4;
        exp_pc  = DM_HALT;
        exp_dbg = 1'b1;
      end else if (exp_dbg && resume_seen) begin
        exp_pc      = exp_dpc;
        exp_dbg     = 1'b0;
        resume_seen = 1'b0;
      end else if (!exp_dbg && (irq_d & MAPPED) != 32'd0) begin
        take_irq = 1'b1;
        cause    = expected_cause(irq_d);
        assert (irq_id == cause)
          else report_mismatch("irq_id_o", 32'(cause), 32'(irq_id));
        exp_pc = MTVEC + 32'(cause) * 32'd4;
      end else begin
        exp_pc = exp_pc + 32'd4;
      end
      assert (irq_ack == take_irq)
        else report_mismatch("irq_ack_o", 32'(take_irq), 32'(irq_ack));
    end
  end

  // --------------------------------------
  // Bus and control rules
  always @(posedge clk) begin
    if (rst) begin
      outstanding <= 1'b0;
    end else if (bus_req.req && bus_rsp.gnt) begin
      outstanding <= 1'b1;
    end else if (bus_rsp.rvalid) begin
      outstanding <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
      bus_req.req && !bus_rsp.gnt |=> bus_req.req)
    else report_mismatch("instr_bus_o.req", 32'd1, 32'(bus_req.req));
  assert property (@(posedge clk) disable iff (rst)
      bus_req.req && !bus_rsp.gnt |=> $stable(bus_req.addr))
    else stop_on_failure("instr_bus_o.addr changed before the grant");
  assert property (@(posedge clk) outstanding |-> !bus_req.req)
    else stop_on_failure("instr_bus_o.req raised while a read was outstanding");
  assert property (@(posedge clk) req_forbidden |-> !bus_req.req && !trace.valid)
    else stop_on_failure("fetch activity during reset or with fetch disabled");
  assert property (@(posedge clk) disable iff (rst) irq_ack |-> trace.valid)
    else stop_on_failure("irq_ack_o pulsed without a trace item");
  assert property (@(posedge clk) disable iff (rst) irq_ack |=> !irq_ack)
    else stop_on_failure("irq_ack_o held for more than one cycle");

  // Watchdog
  initial begin
    repeat (WATCHDOG) @(posedge clk);
    stop_on_failure($sformatf("timeout after %0d cycles", WATCHDOG));
  end

  // --------------------------------------
  // Stimulus
  initial begin
    repeat (2) @(posedge clk);
    req_forbidden <= 1'b1;
    repeat (14) @(posedge clk);
    rst <= 1'b0;
    // Fetch held off for a while after reset
    repeat (8) @(posedge clk);
    assert (!trace.valid && !irq_ack && !debug_mode)
      else stop_on_failure("control output high after reset");
    req_forbidden <= 1'b0;
    fetch_enable  <= 1'b1;
    wait_traces(SEQ_ITEMS);

    // One read still in flight after the drop
    fetch_enable <= 1'b0;
    wait_traces(1);
    req_forbidden <= 1'b1;
    repeat (20) @(posedge clk);
    req_forbidden <= 1'b0;
    fetch_enable  <= 1'b1;

    for (int c = 0; c < 8; c++) begin
      wait_traces(2);
      irq_new    <= IRQ_CASES[c];
      irq_vp_new <= VP_CASES[c];
      irq_load   <= 1'b1;
      @(posedge clk);
      irq_load <= 1'b0;
      // Loaded lines are visible from the next edge
      @(posedge clk);
      while (((irq.raw | irq_vp.raw) & MAPPED) != 32'd0) begin
        @(posedge clk);
      end
    end

    // Debug entry with a timer line pending
    wait_traces(1);
    debug_req  <= 1'b1;
    irq_new    <= 32'h0000_0080;
    irq_vp_new <= 32'd0;
    irq_load   <= 1'b1;
    @(posedge clk);
    irq_load <= 1'b0;
    while (!debug_mode) begin
      @(posedge clk);
    end
    debug_req <= 1'b0;
    wait_traces(4);
    debug_resume <= 1'b1;
    @(posedge clk);
    debug_resume <= 1'b0;
    wait_traces(2);
    assert (!debug_mode)
      else report_mismatch("debug_mode_o", 32'd0, 32'(debug_mode));
    // Timer taken once out of debug mode
    while (((irq.raw | irq_vp.raw) & MAPPED) != 32'd0) begin
      @(posedge clk);
    end
    wait_traces(2);

    $display("TEST PASS");
    $finish;
  end

endmodule

//--- verif/tb_obi_mem.sv
// --------------------------------------
// OBI read-only memory model for the testbench
// Grant and rvalid delays come from a Galois LFSR
// Read data is the address XOR a fixed key
// --------------------------------------

`timescale 1ns/1ps

module tb_obi_mem #(
  parameter logic [31:0] Seed    = 32'h1e54_c0c2,
  parameter logic [31:0] FillKey = 32'ha5a5_5a5a
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  core_shell_pkg::obi_req_t bus_i,
  output core_shell_pkg::obi_rsp_t bus_o
);

  logic [31:0] lfsr_q;
  logic [31:0] step1;
  logic [31:0] step2;
  logic [31:0] step3;
  logic [31:0] step4;
  logic [1:0]  gnt_draw;
  logic [1:0]  rv_draw;
  logic        gnt;

  // Response side, known values before the first reset edge
  logic [1:0]  gnt_cnt_q = 2'd0;
  logic [1:0]  rv_cnt_q  = 2'd0;
  logic        pend_q    = 1'b0;
  logic [31:0] addr_q    = 32'd0;

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // Four bits per grant, one step each
  assign step1    = lfsr_step(lfsr_q);
  assign step2    = lfsr_step(step1);
  assign step3    = lfsr_step(step2);
  assign step4    = lfsr_step(step3);
  assign gnt_draw = {step1[0], step2[0]};
  assign rv_draw  = {step3[0], step4[0]};

  // Grant once the drawn delay has run out, 0 to 3 cycles
  assign gnt = bus_i.req && !pend_q && (gnt_cnt_q == 2'd0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q    <= Seed;
      gnt_cnt_q <= 2'd0;
      rv_cnt_q  <= 2'd0;
      pend_q    <= 1'b0;
      addr_q    <= 32'd0;
    end else begin
      if (bus_i.req && !pend_q && gnt_cnt_q != 2'd0) begin
        gnt_cnt_q <= gnt_cnt_q - 2'd1;
      end
      if (gnt) begin
        // Delays for this response and for the next grant
        lfsr_q    <= step4;
        gnt_cnt_q <= gnt_draw;
        rv_cnt_q  <= (rv_draw == 2'd0) ? 2'd0 : rv_draw - 2'd1;
        pend_q    <= 1'b1;
        addr_q    <= bus_i.addr;
      end else if (pend_q) begin
        if (rv_cnt_q == 2'd0) begin
          pend_q <= 1'b0;
        end else begin
          rv_cnt_q <= rv_cnt_q - 2'd1;
        end
      end
    end
  end

  // Rvalid 1 to 3 cycles after the grant
  assign bus_o = '{gnt:    gnt,
                   rvalid: pend_q && (rv_cnt_q == 2'd0),
                   rdata:  addr_q ^ FillKey};

endmodule
